// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= adamnet_tb
RTL_TOP   ?= adamnet_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation PASSED

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter source/%,$(SRCS))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== files.f ====
source/adamnet_pkg.sv
source/adamnet_mem_if.sv
source/adamnet_snoop.sv
source/adamnet_dispatch.sv
source/adamnet_disk_xfer.sv
source/adamnet_mem_port.sv
source/adamnet_top.sv
sim/adamnet_tb.sv

// ==== sim/adamnet_tb.sv ====
`default_nettype none

module adamnet_tb;
  import adamnet_pkg::*;

  localparam logic [15:0] BASE    = 16'hFEC0;
  localparam int          TIMEOUT = 100000; // Cycles allowed per wait
  localparam logic [2:0]  ILV [8] = '{3'd0, 3'd5, 3'd2, 3'd7, 3'd4, 3'd1, 3'd6, 3'd3};

  logic        clk_i = 1'b0;
  logic        adam_reset_pcb_n_i;
  logic        z80_wr;
  logic [15:0] z80_addr;
  logic [7:0]  z80_data_wr;
  logic [1:0]  disk_present;
  logic        disk_sector_loaded = 1'b0;
  logic [7:0]  disk_data          = 8'h00;
  logic [7:0]  ramb_din           = 8'h00;
  logic        ramb_wr_ack        = 1'b0;
  logic        ramb_rd_ack        = 1'b0;
  logic [15:0] ramb_addr;
  logic        ramb_wr, ramb_rd;
  logic [7:0]  ramb_dout;
  logic [31:0] disk_sector;
  logic        disk_load, disk_flush;
  logic [8:0]  disk_addr;
  logic        adamnet_wait_n, adamnet_sel_n;

  logic [7:0]  ram [0:65535];       // ADAM memory behind the DUT
  logic [7:0]  model_mem [0:65535]; // Expected contents
  logic        poke_en   = 1'b0;    // Preset of one RAM byte
  logic [15:0] poke_addr = '0;
  logic [7:0]  poke_data = '0;
  int          ram_delay   = -1;    // -1 means no access in progress
  int          disk_delay  = -1;
  int          flush_count = 0;
  logic [31:0] loaded_q [$];        // Sectors requested from the disk

  adamnet_top #(.num_disks(2), .pcb_base(BASE)) i_adamnet_top (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic [7:0] fill_byte(input logic [15:0] a);
    fill_byte = a[7:0] ^ {a[12:8], a[15:13]} ^ 8'h3c; // Differs across whole address
  endfunction

  function automatic logic [15:0] dcb_field(input int j, input int off);
    dcb_field = 16'(BASE + PCB_SIZE + j * DCB_SIZE + off);
  endfunction

  function automatic logic [31:0] disk_sector_of(input logic [31:0] s);
    disk_sector_of = {s[31:3], ILV[s[2:0]]};
  endfunction

  // RAM with 0..3 cycles of ack delay
  always @(posedge clk_i) begin
    ramb_wr_ack <= 1'b0;
    ramb_rd_ack <= 1'b0;
    if (!adam_reset_pcb_n_i) begin
      for (int a = 0; a < 65536; a++) ram[16'(a)] = fill_byte(16'(a));
      ram_delay = -1;
    end else begin
      if (poke_en) ram[poke_addr] = poke_data;
      if ((ramb_wr || ramb_rd) && !ramb_wr_ack && !ramb_rd_ack) begin
        if (ram_delay < 0) ram_delay = int'($urandom_range(3, 0));
        if (ram_delay == 0) begin
          if (ramb_wr) ram[ramb_addr] = ramb_dout;
          else ramb_din <= ram[ramb_addr];
          ramb_wr_ack <= ramb_wr;
          ramb_rd_ack <= ramb_rd;
          ram_delay = -1;
        end else begin
          ram_delay = ram_delay - 1;
        end
      end
    end
  end

  // Disk model returns sector low byte XOR address low byte
  always @(posedge clk_i) begin
    disk_data          <= disk_sector[7:0] ^ disk_addr[7:0];
    disk_sector_loaded <= 1'b0;
    if (adam_reset_pcb_n_i && disk_load && !disk_sector_loaded) begin
      if (disk_delay < 0) disk_delay = int'($urandom_range(5, 0));
      if (disk_delay == 0) begin
        disk_sector_loaded <= 1'b1;
        loaded_q.push_back(disk_sector);
        disk_delay = -1;
      end else begin
        disk_delay = disk_delay - 1;
      end
    end
    if (adam_reset_pcb_n_i && disk_flush) flush_count++;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    stop_run($sformatf("FAILED at time %0t: %s = 0x%0h, expected 0x%0h",
                       $time, name, got, exp));
  endtask

  task automatic wait_for_wait_n(input logic level, input string what);
    int n;
    n = 0;
    @(negedge clk_i);
    while (adamnet_wait_n !== level) begin
      n++;
      if (n > TIMEOUT)
        stop_run($sformatf("Timeout: adamnet_wait_n never went %0b during %s", level, what));
      @(negedge clk_i);
    end
  endtask

  task automatic check_memory(input string what);
    for (int a = 0; a < 65536; a++) begin
      assert (ram[16'(a)] === model_mem[16'(a)])
        else value_error($sformatf("%s ram[%04h]", what, a), 32'(ram[16'(a)]),
                         32'(model_mem[16'(a)]));
    end
  endtask

  // Only used while the DUT is idle
  task automatic preset(input logic [15:0] addr, input logic [7:0] data);
    @(posedge clk_i);
    poke_en   <= 1'b1;
    poke_addr <= addr;
    poke_data <= data;
    @(posedge clk_i);
    poke_en <= 1'b0;
    model_mem[addr] = data;
  endtask

  // One Z80 command write, then wait for the whole command
  task automatic send_command(input logic [15:0] addr, input logic [7:0] data,
                              input logic expect_sel, input string what);
    wait_for_wait_n(1'b1, what);
    @(posedge clk_i);
    z80_addr    <= addr;
    z80_data_wr <= data;
    z80_wr      <= 1'b1;
    @(posedge clk_i); // Snoop takes the write here
    @(negedge clk_i);
    assert (adamnet_sel_n === !expect_sel)
      else value_error("adamnet_sel_n", 32'(adamnet_sel_n), 32'(!expect_sel));
    @(posedge clk_i);
    z80_wr <= 1'b0;   // Seen by snoop once idle again
    wait_for_wait_n(1'b0, what);
    wait_for_wait_n(1'b1, what);
  endtask

  task automatic sync_command(input logic [7:0] cmd);
    send_command(BASE, cmd, 1'b0, "PCB command");
    model_mem[BASE] = 8'(RSP_STATUS) | cmd;
    check_memory("PCB command");
  endtask

  // Expected copy of a disk READ, and the sectors it asks for
  task automatic model_read(input int j, input int loads0, output int blocks);
    logic [15:0] buf_a, len;
    logic [31:0] sec;
    logic [31:0] blk_sec; // Disk sector of the current block
    buf_a = {model_mem[dcb_field(j, DCB_BA_HI)], model_mem[dcb_field(j, DCB_BA_LO)]};
    len   = {model_mem[dcb_field(j, DCB_BUF_LEN_HI)], model_mem[dcb_field(j, DCB_BUF_LEN_LO)]};
    sec   = {model_mem[dcb_field(j, DCB_SEC_NUM_3)], model_mem[dcb_field(j, DCB_SEC_NUM_2)],
             model_mem[dcb_field(j, DCB_SEC_NUM_1)], model_mem[dcb_field(j, DCB_SEC_NUM_0)]};
    if (len < 16'(DISK_BUF_MIN)) len = 16'(DISK_BUF_MIN);
    blocks = (int'(len) + 511) / 512;
    for (int i = 0; i < int'(len); i++) begin
      blk_sec = disk_sector_of(sec + 32'(i / 512));
      model_mem[16'(buf_a + i)] = blk_sec[7:0] ^ 8'(i % 512);
    end
    for (int b = 0; b < blocks && loads0 + b < loaded_q.size(); b++) begin
      assert (loaded_q[loads0 + b] === disk_sector_of(sec + 32'(b)))
        else value_error("disk_sector", loaded_q[loads0 + b], disk_sector_of(sec + 32'(b)));
    end
  endtask

  task automatic dcb_command(input int j, input logic [7:0] dev, input logic [7:0] cmd);
    int         flushes0;
    int         loads0;
    int         blocks;
    logic [7:0] node;
    preset(dcb_field(j, DCB_DEV_NUM), dev);
    flushes0 = flush_count;
    loads0   = loaded_q.size();
    send_command(dcb_field(j, DCB_CMD_STAT), cmd, 1'b1, $sformatf("DCB %0d cmd %02h", j, cmd));
    blocks = 0;
    if (dev == 8'd4 || dev == 8'd5) begin // Disk 0 or 1
      if (cmd[7]) begin
        model_mem[dcb_field(j, DCB_CMD_STAT)] = 8'(RSP_STATUS);
      end else begin
        node = model_mem[dcb_field(j, DCB_NODE_TYPE)];
        model_mem[dcb_field(j, DCB_NODE_TYPE)] = {node[7:4], disk_present[dev[0]] ? 4'h0 : 4'h3};
        case (cmd)
          CMD_STATUS: begin
            model_mem[dcb_field(j, DCB_CMD_STAT)] = 8'h80;
            model_mem[dcb_field(j, DCB_MAXL_LO)]  = 8'h00;
            model_mem[dcb_field(j, DCB_MAXL_HI)]  = 8'h04;
            model_mem[dcb_field(j, DCB_DEV_TYPE)] = 8'h01;
          end
          CMD_SOFT_RESET: model_mem[dcb_field(j, DCB_CMD_STAT)] = 8'h80;
          CMD_READ: begin
            model_mem[dcb_field(j, DCB_CMD_STAT)] = 8'h00;
            model_read(j, loads0, blocks);
          end
          default: ; // Unused code rewrites NODE_TYPE only
        endcase
      end
    end else begin
      model_mem[dcb_field(j, DCB_CMD_STAT)] = 8'h00; // Not a disk
    end
    assert (flush_count - flushes0 == blocks)
      else value_error("disk_flush count", 32'(flush_count - flushes0), 32'(blocks));
    assert (loaded_q.size() - loads0 == blocks)
      else value_error("disk_load count", 32'(loaded_q.size() - loads0), 32'(blocks));
    check_memory($sformatf("DCB %0d cmd %02h", j, cmd));
  endtask

  task automatic read_test(input int j, input logic [7:0] dev);
    logic [15:0] buf_a, len;
    logic [31:0] sec;
    buf_a = 16'($urandom_range(16'hEFFF, 0)); // Stays below the tables
    len   = 16'($urandom_range(2048, 1));
    sec   = $urandom();
    preset(dcb_field(j, DCB_BA_LO), buf_a[7:0]);
    preset(dcb_field(j, DCB_BA_HI), buf_a[15:8]);
    preset(dcb_field(j, DCB_BUF_LEN_LO), len[7:0]);
    preset(dcb_field(j, DCB_BUF_LEN_HI), len[15:8]);
    for (int k = 0; k < 4; k++) preset(dcb_field(j, DCB_SEC_NUM_0 + k), sec[k*8 +: 8]);
    dcb_command(j, dev, CMD_READ);
  endtask

  task automatic random_command();
    int         j;
    logic [7:0] dev;
    j = int'($urandom_range(14, 1));
    case ($urandom_range(3, 0))
      0:       dev = 8'd4;
      1:       dev = 8'd5;
      2:       dev = 8'd0;
      default: dev = 8'($urandom());
    endcase
    case ($urandom_range(5, 0))
      0:       sync_command($urandom_range(1, 0) ? 8'(CMD_SYNC2) : 8'(CMD_SYNC1));
      1:       dcb_command(j, dev, CMD_STATUS);
      2:       dcb_command(j, dev, CMD_SOFT_RESET);
      3:       read_test(j, dev);
      4:       dcb_command(j, dev, 8'h80 | 8'($urandom_range(127, 0)));
      default: dcb_command(j, dev, 8'($urandom_range(127, 5))); // No such command
    endcase
  endtask

  initial begin
    void'($urandom(32'h60b0_86c4));
    adam_reset_pcb_n_i <= 1'b0;
    z80_wr             <= 1'b0;
    z80_addr           <= 16'h0000;
    z80_data_wr        <= 8'h00;
    disk_present       <= 2'b01; // Disk 0 present and disk 1 absent
    for (int a = 0; a < 65536; a++) model_mem[16'(a)] = fill_byte(16'(a));
    model_mem[BASE + 16'(PCB_BA_LO)]   = BASE[7:0];
    model_mem[BASE + 16'(PCB_BA_HI)]   = BASE[15:8];
    model_mem[BASE + 16'(PCB_MAX_DCB)] = 8'd15;
    for (int j = 0; j < NUM_DCB; j++) begin
      model_mem[dcb_field(j, DCB_DEV_NUM)]  = 8'h00;
      model_mem[dcb_field(j, DCB_ADD_CODE)] = 8'(j);
    end
    repeat (4) @(posedge clk_i);
    adam_reset_pcb_n_i <= 1'b1;
    @(negedge clk_i); // Outputs still quiet as setup starts
    assert ({ramb_wr, ramb_rd, disk_load, disk_flush, adamnet_wait_n} === 5'b0)
      else value_error("outputs after reset",
                       32'({ramb_wr, ramb_rd, disk_load, disk_flush, adamnet_wait_n}), 32'h0);
    wait_for_wait_n(1'b1, "table setup");
    check_memory("table setup");

    sync_command(CMD_SYNC1);
    sync_command(CMD_SYNC2);
    dcb_command(3, 8'd4, CMD_STATUS);      // Present disk
    dcb_command(3, 8'd5, CMD_STATUS);      // Absent disk
    dcb_command(3, 8'd4, CMD_SOFT_RESET);
    dcb_command(6, 8'd4, 8'h80 | 8'($urandom_range(127, 0)));
    dcb_command(7, 8'd2, CMD_STATUS);      // Unknown device
    read_test(3, 8'd4);
    read_test(9, 8'd5);
    for (int k = 0; k < 24; k++) random_command();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/adamnet_disk_xfer.sv ====
`default_nettype none

module adamnet_disk_xfer (
  input  logic             clk_i,
  input  logic             adam_reset_pcb_n_i,
  input  logic             start,
  input  logic [15:0]      buf_addr,
  input  logic [31:0]      sector,
  input  logic [15:0]      length,
  output logic             busy,
  output logic [31:0]      disk_sector,
  output logic             disk_load,
  output logic [8:0]       disk_addr,
  output logic             disk_flush,
  input  logic             disk_sector_loaded,
  input  logic [7:0]       disk_data,
  adamnet_mem_if.requester mem
);
  import adamnet_pkg::*;

  typedef enum logic [2:0] {X_IDLE, X_LOAD, X_NEXT, X_CAP, X_WRITE} state_e;

  state_e      state;
  logic [31:0] sec_q;    // Logical sector before interleave
  logic [15:0] addr_q;   // Next ADAM address
  logic [15:0] remain;   // Bytes still to copy
  logic [9:0]  byte_q;   // Byte in block where 512 means block done
  logic        req_q;
  logic [7:0]  wdata_q;

  assign busy        = (state != X_IDLE);
  assign disk_load   = (state == X_LOAD);
  assign disk_sector = {sec_q[31:3], interleave(sec_q[2:0])};
  assign disk_addr   = byte_q[8:0];

  assign mem.req      = req_q;
  assign mem.wr       = 1'b1;     // Disk READ only writes RAM
  assign mem.space    = SPACE_ABS;
  assign mem.dev      = '0;
  assign mem.offset   = '0;
  assign mem.abs_addr = addr_q;
  assign mem.wdata    = wdata_q;

  always_ff @(posedge clk_i) begin
    disk_flush <= 1'b0;
    case (state)
      X_IDLE: begin
        if (start) begin
          sec_q  <= sector;
          addr_q <= buf_addr;
          remain <= length;
          state  <= X_LOAD;
        end
      end
      X_LOAD: begin
        if (disk_sector_loaded) begin
          byte_q <= '0;
          state  <= X_NEXT; // disk_addr settles here
        end
      end
      X_NEXT: begin
        if (remain == 16'd0) begin
          disk_flush <= 1'b1;
          state      <= X_IDLE;
        end else if (byte_q == 10'(SECTOR_BYTES)) begin
          disk_flush <= 1'b1; // Next sector after a full block
          sec_q      <= sec_q + 32'd1;
          state      <= X_LOAD;
        end else begin
          state <= X_CAP;
        end
      end
      X_CAP: begin // disk_data valid one cycle after disk_addr
        wdata_q <= disk_data;
        req_q   <= 1'b1;
        state   <= X_WRITE;
      end
      X_WRITE: begin
        if (mem.done) begin
          req_q  <= 1'b0;
          addr_q <= addr_q + 16'd1;
          byte_q <= byte_q + 10'd1;
          remain <= remain - 16'd1;
          state  <= X_NEXT;
        end
      end
      default: state <= X_IDLE;
    endcase
    if (!adam_reset_pcb_n_i) begin
      state      <= X_IDLE;
      req_q      <= 1'b0;
      disk_flush <= 1'b0;
    end
  end

  // Port answers only a pending write and never during a sector load
  a_load_vs_req: assert property (@(posedge clk_i) disable iff (!adam_reset_pcb_n_i)
    mem.done |-> (mem.req && !disk_load));

endmodule

`default_nettype wire

// ==== source/adamnet_dispatch.sv ====
`default_nettype none

module adamnet_dispatch #(
  parameter int          num_disks = 1,
  parameter logic [15:0] pcb_base  = adamnet_pkg::PCB_BASE_INIT
) (
  input  logic                 clk_i,
  input  logic                 adam_reset_pcb_n_i,
  input  logic                 ev_valid,
  input  logic                 ev_pcb,
  input  adamnet_pkg::dev_t    ev_dev,
  input  logic [7:0]           ev_data,
  input  logic [num_disks-1:0] disk_present,
  adamnet_mem_if.requester     mem,
  output logic                 idle,
  output logic                 adamnet_wait_n,
  output logic                 xfer_start,
  output logic [15:0]          xfer_buf_addr,
  output logic [31:0]          xfer_sector,
  output logic [15:0]          xfer_length,
  input  logic                 xfer_busy
);
  import adamnet_pkg::*;

  typedef enum logic [3:0] {
    S_SETUP, S_INIT_DCB, S_INIT_NEXT, S_IDLE, S_MEM, S_DEV, S_NODE,
    S_DISK_CMD, S_STATUS, S_RD_PARAM, S_RD_STORE, S_XFER_START, S_XFER_WAIT
  } state_e;

  state_e      state, ret_q;
  logic [4:0]  step;
  logic        req_q, wr_q;
  mem_space_e  space_q;
  dev_t        dev_q;
  logic [4:0]  off_q;
  logic [7:0]  wdata_q, rdata_q;
  logic [7:0]  cmd_q;      // Command byte from the event
  logic [1:0]  disk_q;     // Disk index, DEV_NUM - 4
  logic [3:0]  present_ext;
  logic [63:0] prm_q;      // SEC_NUM_3..0, BUF_LEN, BA as read from the DCB
  logic [4:0]  st_off;
  logic [7:0]  st_val;

  assign mem.req      = req_q;
  assign mem.wr       = wr_q;
  assign mem.space    = space_q;
  assign mem.dev      = dev_q;
  assign mem.offset   = off_q;
  assign mem.abs_addr = '0;  // Only table accesses from here
  assign mem.wdata    = wdata_q;

  assign idle           = (state == S_IDLE);
  assign adamnet_wait_n = (state == S_IDLE); // Z80 may issue next command
  assign present_ext    = 4'(disk_present);

  assign xfer_start    = (state == S_XFER_START);
  assign xfer_buf_addr = prm_q[15:0];
  assign xfer_sector   = prm_q[63:32];
  assign xfer_length   = (prm_q[31:16] < 16'(DISK_BUF_MIN)) ? 16'(DISK_BUF_MIN) : prm_q[31:16];

  // STATUS reply, four DCB writes
  always_comb begin
    case (step[1:0])
      2'd0:    begin st_off = DCB_CMD_STAT; st_val = RSP_STATUS; end
      2'd1:    begin st_off = DCB_MAXL_LO;  st_val = 8'h00;      end
      2'd2:    begin st_off = DCB_MAXL_HI;  st_val = 8'h04;      end // 1 KB blocks
      default: begin st_off = DCB_DEV_TYPE; st_val = 8'h01;      end // Block device
    endcase
  end

  // Start a memory access and come back to ret
  task automatic issue(input logic w, input mem_space_e sp, input logic [4:0] off,
                       input logic [7:0] data, input state_e ret);
    req_q   <= 1'b1;
    wr_q    <= w;
    space_q <= sp;
    off_q   <= off;
    wdata_q <= data;
    ret_q   <= ret;
    state   <= S_MEM;
  endtask

  always_ff @(posedge clk_i) begin
    case (state)
      S_SETUP: begin
        step <= step + 5'd1;
        case (step[1:0])
          2'd0: issue(1'b1, SPACE_PCB, 5'(PCB_BA_LO), pcb_base[7:0], S_SETUP);
          2'd1: issue(1'b1, SPACE_PCB, 5'(PCB_BA_HI), pcb_base[15:8], S_SETUP);
          default: begin
            issue(1'b1, SPACE_PCB, 5'(PCB_MAX_DCB), 8'(NUM_DCB), S_INIT_DCB);
            step  <= '0;
            dev_q <= '0;
          end
        endcase
      end
      S_INIT_DCB: begin
        if (!step[0]) begin
          issue(1'b1, SPACE_DCB, DCB_DEV_NUM, 8'h00, S_INIT_DCB);
          step <= 5'd1;
        end else begin
          issue(1'b1, SPACE_DCB, DCB_ADD_CODE, {4'h0, dev_q}, S_INIT_NEXT);
        end
      end
      S_INIT_NEXT: begin
        step <= '0;
        if (dev_q == dev_t'(NUM_DCB - 1)) state <= S_IDLE;
        else begin
          dev_q <= dev_q + 4'd1;
          state <= S_INIT_DCB;
        end
      end
      S_IDLE: begin
        if (ev_valid) begin
          cmd_q <= ev_data;
          dev_q <= ev_dev;
          if (!ev_pcb) issue(1'b0, SPACE_DCB, DCB_DEV_NUM, 8'h00, S_DEV);
          else if (ev_data == CMD_SYNC1 || ev_data == CMD_SYNC2)
            issue(1'b1, SPACE_PCB, 5'(PCB_CMD_STAT), 8'(RSP_STATUS) | ev_data, S_IDLE);
        end
      end
      S_MEM: begin
        if (mem.done) begin
          req_q   <= 1'b0;      // Low in the cycle after done
          rdata_q <= mem.rdata;
          state   <= ret_q;
        end
      end
      S_DEV: begin // rdata_q holds DEV_NUM
        disk_q <= rdata_q[1:0];
        if (rdata_q[7:2] == 6'd1 && int'(rdata_q[1:0]) < num_disks) begin
          if (cmd_q[7]) issue(1'b1, SPACE_DCB, DCB_CMD_STAT, RSP_STATUS, S_IDLE);
          else issue(1'b0, SPACE_DCB, DCB_NODE_TYPE, 8'h00, S_NODE);
        end else begin
          issue(1'b1, SPACE_DCB, DCB_CMD_STAT, 8'h00, S_IDLE); // Unknown device
        end
      end
      S_NODE: issue(1'b1, SPACE_DCB, DCB_NODE_TYPE,
                    {rdata_q[7:4], 2'b00, present_ext[disk_q] ? 2'b00 : 2'b11}, S_DISK_CMD);
      S_DISK_CMD: begin
        step <= '0;
        case (cmd_q)
          CMD_STATUS:     state <= S_STATUS;
          CMD_SOFT_RESET: issue(1'b1, SPACE_DCB, DCB_CMD_STAT, RSP_STATUS, S_IDLE);
          CMD_READ:       issue(1'b1, SPACE_DCB, DCB_CMD_STAT, 8'h00, S_RD_PARAM); // Busy
          default:        state <= S_IDLE;
        endcase
      end
      S_STATUS: begin
        step <= step + 5'd1;
        if (step[1:0] == 2'd3) issue(1'b1, SPACE_DCB, st_off, st_val, S_IDLE);
        else issue(1'b1, SPACE_DCB, st_off, st_val, S_STATUS);
      end
      S_RD_PARAM: issue(1'b0, SPACE_DCB, 5'(DCB_BA_LO + step), 8'h00, S_RD_STORE);
      S_RD_STORE: begin // Fields BA_LO..SEC_NUM_3 are consecutive
        prm_q[step[2:0]*8 +: 8] <= rdata_q;
        step                    <= step + 5'd1;
        state                   <= (step[2:0] == 3'd7) ? S_XFER_START : S_RD_PARAM;
      end
      S_XFER_START: state <= S_XFER_WAIT; // xfer_busy is up next cycle
      S_XFER_WAIT:  if (!xfer_busy) state <= S_IDLE;
      default:      state <= S_IDLE;
    endcase
    if (!adam_reset_pcb_n_i) begin
      state <= S_SETUP; // Table setup runs after every reset
      step  <= '0;
      req_q <= 1'b0;
    end
  end

  // Snoop only offers commands when this FSM can take them
  a_ev_when_idle: assert property (@(posedge clk_i) disable iff (!adam_reset_pcb_n_i)
    ev_valid |-> idle);

endmodule

`default_nettype wire

// ==== source/adamnet_mem_if.sv ====
`default_nettype none

// One byte access toward ADAM memory
interface adamnet_mem_if;
  logic                     req;      // Level, held until done
  logic                     wr;       // 1 write, 0 read
  adamnet_pkg::mem_space_e  space;
  adamnet_pkg::dev_t        dev;      // DCB index for SPACE_DCB
  logic [4:0]               offset;   // Field offset in PCB or DCB
  logic [15:0]              abs_addr; // Used for SPACE_ABS only
  logic [7:0]               wdata;
  logic [7:0]               rdata;    // Valid with done
  logic                     done;     // Single cycle

  modport requester (output req, wr, space, dev, offset, abs_addr, wdata,
                     input rdata, done);
  modport port (input req, wr, space, dev, offset, abs_addr, wdata,
                output rdata, done);
endinterface

`default_nettype wire

// ==== source/adamnet_mem_port.sv ====
`default_nettype none

module adamnet_mem_port #(
  parameter logic [15:0] pcb_base = adamnet_pkg::PCB_BASE_INIT
) (
  input  logic        clk_i,
  input  logic        adam_reset_pcb_n_i,
  adamnet_mem_if.port cmd,
  adamnet_mem_if.port xfer,
  output logic [15:0] ramb_addr,
  output logic        ramb_wr,
  output logic        ramb_rd,
  output logic [7:0]  ramb_dout,
  input  logic [7:0]  ramb_din,
  input  logic        ramb_wr_ack,
  input  logic        ramb_rd_ack
);
  import adamnet_pkg::*;

  typedef enum logic [1:0] {P_IDLE, P_ACCESS, P_DONE} state_e;

  localparam logic [15:0] DCB_BASE = 16'(pcb_base + PCB_SIZE);

  state_e      state;
  logic        owner_xfer; // Which requester is being served
  logic        sel_wr;
  mem_space_e  sel_space;
  dev_t        sel_dev;
  logic [4:0]  sel_off;
  logic [15:0] sel_abs;
  logic [15:0] addr_c;
  logic [7:0]  rdata_q;

  // Requesters are never active together
  assign sel_wr    = xfer.req ? xfer.wr       : cmd.wr;
  assign sel_space = xfer.req ? xfer.space    : cmd.space;
  assign sel_dev   = xfer.req ? xfer.dev      : cmd.dev;
  assign sel_off   = xfer.req ? xfer.offset   : cmd.offset;
  assign sel_abs   = xfer.req ? xfer.abs_addr : cmd.abs_addr;

  always_comb begin
    case (sel_space)
      SPACE_PCB: addr_c = pcb_base + 16'(sel_off);
      SPACE_DCB: addr_c = DCB_BASE + 16'(sel_dev * DCB_SIZE) + 16'(sel_off);
      default:   addr_c = sel_abs;
    endcase
  end

  assign cmd.rdata  = rdata_q;
  assign xfer.rdata = rdata_q;
  assign cmd.done   = (state == P_DONE) && !owner_xfer;
  assign xfer.done  = (state == P_DONE) && owner_xfer;

  always_ff @(posedge clk_i) begin
    case (state)
      P_IDLE: begin
        if (cmd.req || xfer.req) begin
          owner_xfer <= xfer.req;
          ramb_addr  <= addr_c;
          ramb_dout  <= xfer.req ? xfer.wdata : cmd.wdata;
          ramb_wr    <= sel_wr;
          ramb_rd    <= !sel_wr;
          state      <= P_ACCESS;
        end
      end
      P_ACCESS: begin // Strobe held until RAM acks
        if ((ramb_wr && ramb_wr_ack) || (ramb_rd && ramb_rd_ack)) begin
          ramb_wr <= 1'b0;
          ramb_rd <= 1'b0;
          rdata_q <= ramb_din;
          state   <= P_DONE;
        end
      end
      default: state <= P_IDLE; // Requester drops req during done
    endcase
    if (!adam_reset_pcb_n_i) begin
      state   <= P_IDLE;
      ramb_wr <= 1'b0;
      ramb_rd <= 1'b0;
    end
  end

  a_one_requester: assert property (@(posedge clk_i) disable iff (!adam_reset_pcb_n_i)
    !(cmd.req && xfer.req));

endmodule

`default_nettype wire

// ==== source/adamnet_pkg.sv ====
`default_nettype none

package adamnet_pkg;

  // PCB layout
  typedef enum logic [1:0] {
    PCB_CMD_STAT = 2'd0,
    PCB_BA_LO    = 2'd1,
    PCB_BA_HI    = 2'd2,
    PCB_MAX_DCB  = 2'd3
  } pcb_off_e;
  localparam int PCB_SIZE = 4;

  // DCB layout, byte offsets inside one block
  typedef enum logic [4:0] {
    DCB_CMD_STAT   = 5'd0,
    DCB_BA_LO      = 5'd1,
    DCB_BA_HI      = 5'd2,
    DCB_BUF_LEN_LO = 5'd3,
    DCB_BUF_LEN_HI = 5'd4,
    DCB_SEC_NUM_0  = 5'd5,
    DCB_SEC_NUM_1  = 5'd6,
    DCB_SEC_NUM_2  = 5'd7,
    DCB_SEC_NUM_3  = 5'd8,
    DCB_DEV_NUM    = 5'd9,
    DCB_ADD_CODE   = 5'd16,
    DCB_MAXL_LO    = 5'd17,
    DCB_MAXL_HI    = 5'd18,
    DCB_DEV_TYPE   = 5'd19,
    DCB_NODE_TYPE  = 5'd20
  } dcb_off_e;
  localparam int DCB_SIZE = 21;
  localparam int NUM_DCB  = 15;

  typedef enum logic [7:0] {CMD_SYNC1 = 8'h01, CMD_SYNC2 = 8'h02} pcb_cmd_e;
  typedef enum logic [7:0] {
    CMD_STATUS     = 8'h01,
    CMD_SOFT_RESET = 8'h02,
    CMD_READ       = 8'h04
  } dcb_cmd_e;
  typedef enum logic [7:0] {RSP_STATUS = 8'h80} rsp_e;

  localparam int DISK_BUF_MIN = 1024; // Disk transfers never shorter
  localparam int SECTOR_BYTES = 512;

  // How mem_port builds the RAM address
  typedef enum logic [1:0] {SPACE_PCB, SPACE_DCB, SPACE_ABS} mem_space_e;

  typedef logic [3:0] dev_t; // DCB index

  localparam logic [15:0] PCB_BASE_INIT = 16'hFEC0;

  // ADAM disk interleave of the low 3 sector bits
  function automatic logic [2:0] interleave(input logic [2:0] sec);
    case (sec)
      3'd0:    interleave = 3'd0;
      3'd1:    interleave = 3'd5;
      3'd2:    interleave = 3'd2;
      3'd3:    interleave = 3'd7;
      3'd4:    interleave = 3'd4;
      3'd5:    interleave = 3'd1;
      3'd6:    interleave = 3'd6;
      default: interleave = 3'd3;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== source/adamnet_snoop.sv ====
`default_nettype none

module adamnet_snoop #(
  parameter logic [15:0] pcb_base = adamnet_pkg::PCB_BASE_INIT
) (
  input  logic              clk_i,
  input  logic              adam_reset_pcb_n_i,
  input  logic              z80_wr,
  input  logic [15:0]       z80_addr,
  input  logic [7:0]        z80_data_wr,
  input  logic              idle,          // Dispatch can take an event
  output logic              ev_valid,
  output logic              ev_pcb,        // Event is for the PCB
  output adamnet_pkg::dev_t ev_dev,
  output logic [7:0]        ev_data,
  output logic              adamnet_sel_n
);
  import adamnet_pkg::*;

  logic [15:0] addr_last;
  logic        wr_last;
  logic        pcb_hit;
  logic        dcb_hit;
  dev_t        hit_dev;
  logic        fresh;

  assign pcb_hit = (z80_addr == pcb_base); // PCB command byte itself

  // Command byte of DCB 1..14
  always_comb begin
    dcb_hit = 1'b0;
    hit_dev = '0;
    for (int i = 1; i < NUM_DCB; i++) begin
      if (z80_addr == 16'(pcb_base + PCB_SIZE + i * DCB_SIZE)) begin
        dcb_hit = 1'b1;
        hit_dev = dev_t'(i);
      end
    end
  end

  // Bus moved since last capture; one event at a time
  assign fresh = idle && !ev_valid && (z80_addr != addr_last || z80_wr != wr_last);

  always_ff @(posedge clk_i) begin
    ev_valid      <= 1'b0;
    adamnet_sel_n <= ~dcb_hit; // Independent of busy state
    if (fresh) begin
      addr_last <= z80_addr;
      wr_last   <= z80_wr;
      if (z80_wr && (pcb_hit || dcb_hit)) begin
        ev_valid <= 1'b1;
        ev_pcb   <= pcb_hit;
        ev_dev   <= hit_dev;
        ev_data  <= z80_data_wr; // Command byte written by Z80
      end
    end
    if (!adam_reset_pcb_n_i) begin
      ev_valid      <= 1'b0;
      adamnet_sel_n <= 1'b1;
      addr_last     <= '1;  // Nothing seen yet
      wr_last       <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== source/adamnet_top.sv ====
`default_nettype none

module adamnet_top #(
  parameter int          num_disks = 1,
  parameter logic [15:0] pcb_base  = adamnet_pkg::PCB_BASE_INIT
) (
  input  logic                 clk_i,
  input  logic                 adam_reset_pcb_n_i,
  input  logic                 z80_wr,
  input  logic [15:0]          z80_addr,
  input  logic [7:0]           z80_data_wr,
  input  logic [num_disks-1:0] disk_present,
  input  logic                 disk_sector_loaded,
  input  logic [7:0]           disk_data,
  input  logic [7:0]           ramb_din,
  input  logic                 ramb_wr_ack,
  input  logic                 ramb_rd_ack,
  output logic [15:0]          ramb_addr,
  output logic                 ramb_wr,
  output logic                 ramb_rd,
  output logic [7:0]           ramb_dout,
  output logic [31:0]          disk_sector,
  output logic                 disk_load,
  output logic [8:0]           disk_addr,
  output logic                 disk_flush,
  output logic                 adamnet_wait_n,
  output logic                 adamnet_sel_n
);
  import adamnet_pkg::*;

  logic        ev_valid, ev_pcb, idle;
  dev_t        ev_dev;
  logic [7:0]  ev_data;
  logic        xfer_start, xfer_busy;
  logic [15:0] xfer_buf_addr, xfer_length;
  logic [31:0] xfer_sector;

  adamnet_mem_if mem_cmd ();  // Table accesses
  adamnet_mem_if mem_xfer (); // Sector data

  adamnet_snoop #(.pcb_base(pcb_base)) i_snoop (
    .clk_i, .adam_reset_pcb_n_i, .z80_wr, .z80_addr, .z80_data_wr,
    .idle, .ev_valid, .ev_pcb, .ev_dev, .ev_data, .adamnet_sel_n
  );

  adamnet_dispatch #(.num_disks(num_disks), .pcb_base(pcb_base)) i_dispatch (
    .clk_i, .adam_reset_pcb_n_i, .ev_valid, .ev_pcb, .ev_dev, .ev_data,
    .disk_present, .mem(mem_cmd.requester), .idle, .adamnet_wait_n,
    .xfer_start, .xfer_buf_addr, .xfer_sector, .xfer_length, .xfer_busy
  );

  adamnet_disk_xfer i_disk_xfer (
    .clk_i, .adam_reset_pcb_n_i,
    .start(xfer_start), .buf_addr(xfer_buf_addr), .sector(xfer_sector),
    .length(xfer_length), .busy(xfer_busy),
    .disk_sector, .disk_load, .disk_addr, .disk_flush,
    .disk_sector_loaded, .disk_data, .mem(mem_xfer.requester)
  );

  adamnet_mem_port #(.pcb_base(pcb_base)) i_mem_port (
    .clk_i, .adam_reset_pcb_n_i,
    .cmd(mem_cmd.port), .xfer(mem_xfer.port),
    .ramb_addr, .ramb_wr, .ramb_rd, .ramb_dout,
    .ramb_din, .ramb_wr_ack, .ramb_rd_ack
  );

endmodule

`default_nettype wire
